/* include/dma_core_params.svh */
// ========================================
// widths, RAM depth and register offsets of the DMA core
// include wherever a macro below is needed
// ========================================
`ifndef DMA_CORE_PARAMS_SVH
`define DMA_CORE_PARAMS_SVH

// data path
`define DATA_W       32
`define RAM_ADDR_W   10
`define RAM_DEPTH    (1 << `RAM_ADDR_W)

// register port and descriptor fields
`define REG_ADDR_W   12
`define TAG_W        8
`define LEN_W        16

// register map, byte offsets
`define REG_ENABLE   12'h000
`define REG_SRC      12'h100
`define REG_DST      12'h104
`define REG_LEN      12'h108
`define REG_TAG      12'h10C
`define REG_STATUS   12'h110
`define REG_DONE_CNT 12'h400

`endif

/* logic/dma_core_pkg.sv */
// ========================================
// shared vector types and the copy FSM states
// referenced by scoped name from the RTL
// ========================================
`default_nettype none

`include "dma_core_params.svh"

package dma_core_pkg;

    // one RAM or register word
    typedef logic [`DATA_W-1:0] data_t;

    // word address into local RAM
    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

    // byte address on the register port
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [`TAG_W-1:0] tag_t;

    // copy length in words
    typedef logic [`LEN_W-1:0] len_t;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        WAIT_DATA,
        WRITE,
        DONE
    } copy_state_t;

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
// ========================================
// request bus from one client to the RAM arbiter
// gnt marks the access cycle, rvalid follows one cycle later
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "dma_core_params.svh"

interface mem_bus_if;

    logic                   req;
    logic                   we;
    logic [`RAM_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]     wdata;
    logic                   gnt;
    logic                   rvalid;
    logic [`DATA_W-1:0]     rdata;

    modport client (output req, we, addr, wdata, input gnt, rvalid, rdata);

    modport arbiter (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

/* logic/local_ram.sv */
// ========================================
// single-port word RAM, read data one cycle after enable
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "dma_core_params.svh"

module local_ram (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  ram_we,
    input  wire logic                  ram_en,
    input  dma_core_pkg::ram_addr_t    ram_addr,
    input  dma_core_pkg::data_t        ram_wdata,
    output dma_core_pkg::data_t        ram_rdata
);

    dma_core_pkg::data_t mem [`RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (ram_en && ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // output register, held between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            ram_rdata <= '0;
        end else if (ram_en && !ram_we) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

/* logic/ram_arbiter.sv */
// ========================================
// round-robin share of the local RAM between host and copy engine
// read data goes back only to the client that issued the read
// ========================================
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    mem_bus_if.arbiter              host,
    mem_bus_if.arbiter              engine,
    output logic                    ram_en,
    output logic                    ram_we,
    output dma_core_pkg::ram_addr_t ram_addr,
    output dma_core_pkg::data_t     ram_wdata,
    input  dma_core_pkg::data_t     ram_rdata
);

    logic last_engine;
    logic host_gnt;
    logic engine_gnt;
    logic rd_host_q;
    logic rd_engine_q;

    // on a tie the client not served last wins
    assign host_gnt = host.req && (!engine.req || last_engine);
    assign engine_gnt = engine.req && !host_gnt;

    assign host.gnt = host_gnt;
    assign engine.gnt = engine_gnt;

    assign ram_en = host_gnt || engine_gnt;
    assign ram_we = host_gnt ? host.we : engine.we;
    assign ram_addr = host_gnt ? host.addr : engine.addr;
    assign ram_wdata = host_gnt ? host.wdata : engine.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_engine <= 1'b0;
            rd_host_q <= 1'b0;
            rd_engine_q <= 1'b0;
        end else begin
            if (host_gnt) begin
                last_engine <= 1'b0;
            end else if (engine_gnt) begin
                last_engine <= 1'b1;
            end
            // owner of the read in flight
            rd_host_q <= host_gnt && !host.we;
            rd_engine_q <= engine_gnt && !engine.we;
        end
    end

    assign host.rvalid = rd_host_q;
    assign host.rdata = rd_host_q ? ram_rdata : '0;
    assign engine.rvalid = rd_engine_q;
    assign engine.rdata = rd_engine_q ? ram_rdata : '0;

endmodule

`default_nettype wire

/* logic/copy_engine.sv */
// ========================================
// copies len words from src to dst inside the local RAM
// one read then one write per word, completion pulses done with the tag
// ========================================
`timescale 1ns/1ps
`default_nettype none

module copy_engine (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               enable,
    input  wire logic               desc_valid,
    input  dma_core_pkg::ram_addr_t desc_src,
    input  dma_core_pkg::ram_addr_t desc_dst,
    input  dma_core_pkg::len_t      desc_len,
    input  dma_core_pkg::tag_t      desc_tag,
    output logic                    desc_ready,
    output logic                    done,
    output dma_core_pkg::tag_t      done_tag,
    mem_bus_if.client               bus
);

    dma_core_pkg::copy_state_t state;
    dma_core_pkg::ram_addr_t   src_q;
    dma_core_pkg::ram_addr_t   dst_q;
    dma_core_pkg::len_t        len_q;
    dma_core_pkg::len_t        idx_q;
    dma_core_pkg::tag_t        tag_q;
    dma_core_pkg::data_t       word_q;
    dma_core_pkg::ram_addr_t   offset;
    logic                      take;

    assign take = (state == dma_core_pkg::IDLE) && enable && desc_valid;
    assign desc_ready = take;
    assign done = (state == dma_core_pkg::DONE);
    assign done_tag = tag_q;

    // addresses wrap at the RAM depth
    assign offset = dma_core_pkg::ram_addr_t'(idx_q);

    always_comb begin
        bus.req = (state == dma_core_pkg::READ) || (state == dma_core_pkg::WRITE);
        bus.we = (state == dma_core_pkg::WRITE);
        bus.addr = (state == dma_core_pkg::WRITE) ? dst_q + offset : src_q + offset;
        bus.wdata = word_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dma_core_pkg::IDLE;
            idx_q <= '0;
        end else begin
            case (state)
                dma_core_pkg::IDLE: begin
                    if (take) begin
                        src_q <= desc_src;
                        dst_q <= desc_dst;
                        len_q <= desc_len;
                        tag_q <= desc_tag;
                        idx_q <= '0;
                        state <= (desc_len == '0) ? dma_core_pkg::DONE : dma_core_pkg::READ;
                    end
                end
                dma_core_pkg::READ: begin
                    if (bus.gnt) begin
                        state <= dma_core_pkg::WAIT_DATA;
                    end
                end
                dma_core_pkg::WAIT_DATA: begin
                    if (bus.rvalid) begin
                        word_q <= bus.rdata;
                        state <= dma_core_pkg::WRITE;
                    end
                end
                dma_core_pkg::WRITE: begin
                    if (bus.gnt) begin
                        idx_q <= idx_q + 1'b1;
                        // last word written
                        if (idx_q + 1'b1 == len_q) begin
                            state <= dma_core_pkg::DONE;
                        end else begin
                            state <= dma_core_pkg::READ;
                        end
                    end
                end
                default: begin
                    state <= dma_core_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/ctrl_regs.sv */
// ========================================
// host control registers, descriptor hand-off and completion status
// status is popped by reading it, irq follows the pending bit
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "dma_core_params.svh"

module ctrl_regs (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                reg_wr,
    input  wire logic                reg_rd,
    input  dma_core_pkg::reg_addr_t  reg_addr,
    input  dma_core_pkg::data_t      reg_wdata,
    output dma_core_pkg::data_t      reg_rdata,
    output logic                     reg_rvalid,
    output logic                     enable,
    output logic                     desc_valid,
    output dma_core_pkg::ram_addr_t  desc_src,
    output dma_core_pkg::ram_addr_t  desc_dst,
    output dma_core_pkg::len_t       desc_len,
    output dma_core_pkg::tag_t       desc_tag,
    input  wire logic                desc_ready,
    input  wire logic                done,
    input  dma_core_pkg::tag_t       done_tag,
    output logic                     irq
);

    dma_core_pkg::tag_t  status_tag;
    dma_core_pkg::data_t done_cnt;
    dma_core_pkg::data_t rd_word;
    logic                pending;
    logic                pop;

    assign pop = reg_rd && (reg_addr == `REG_STATUS);
    assign irq = pending;

    // read mux, fields come back zero-extended from their stored width
    always_comb begin
        rd_word = '0;
        case (reg_addr)
            `REG_ENABLE:   rd_word[0] = enable;
            `REG_SRC:      rd_word[`RAM_ADDR_W-1:0] = desc_src;
            `REG_DST:      rd_word[`RAM_ADDR_W-1:0] = desc_dst;
            `REG_LEN:      rd_word[`LEN_W-1:0] = desc_len;
            `REG_TAG:      rd_word[`TAG_W-1:0] = desc_tag;
            `REG_STATUS: begin
                rd_word[`TAG_W-1:0] = status_tag;
                rd_word[`DATA_W-1] = pending;
            end
            `REG_DONE_CNT: rd_word = done_cnt;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_wr) begin
            case (reg_addr)
                `REG_SRC: desc_src <= reg_wdata[`RAM_ADDR_W-1:0];
                `REG_DST: desc_dst <= reg_wdata[`RAM_ADDR_W-1:0];
                `REG_LEN: desc_len <= reg_wdata[`LEN_W-1:0];
                `REG_TAG: desc_tag <= reg_wdata[`TAG_W-1:0];
                default: ;
            endcase
        end
        if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            desc_valid <= 1'b0;
            pending <= 1'b0;
            status_tag <= '0;
            done_cnt <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            if (reg_wr && reg_addr == `REG_ENABLE) begin
                enable <= reg_wdata[0];
            end
            // a new tag write re-arms even if the engine takes the old one now
            if (desc_ready) begin
                desc_valid <= 1'b0;
            end
            if (reg_wr && reg_addr == `REG_TAG) begin
                desc_valid <= 1'b1;
            end
            if (pop) begin
                pending <= 1'b0;
            end
            // done beats a same-cycle pop
            if (done) begin
                pending <= 1'b1;
                status_tag <= done_tag;
                done_cnt <= done_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dma_core.sv */
// ========================================
// top level of the DMA core, host register and RAM ports
// host and copy engine share the local RAM through the arbiter
// ========================================
`timescale 1ns/1ps
`default_nettype none

module dma_core (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                reg_wr,
    input  wire logic                reg_rd,
    input  dma_core_pkg::reg_addr_t  reg_addr,
    input  dma_core_pkg::data_t      reg_wdata,
    output dma_core_pkg::data_t      reg_rdata,
    output logic                     reg_rvalid,
    input  wire logic                mem_req,
    input  wire logic                mem_we,
    input  dma_core_pkg::ram_addr_t  mem_addr,
    input  dma_core_pkg::data_t      mem_wdata,
    output logic                     mem_gnt,
    output logic                     mem_rvalid,
    output dma_core_pkg::data_t      mem_rdata,
    output logic                     irq
);

    logic                    enable;
    logic                    desc_valid;
    logic                    desc_ready;
    dma_core_pkg::ram_addr_t desc_src;
    dma_core_pkg::ram_addr_t desc_dst;
    dma_core_pkg::len_t      desc_len;
    dma_core_pkg::tag_t      desc_tag;
    logic                    done;
    dma_core_pkg::tag_t      done_tag;
    logic                    ram_en;
    logic                    ram_we;
    dma_core_pkg::ram_addr_t ram_addr;
    dma_core_pkg::data_t     ram_wdata;
    dma_core_pkg::data_t     ram_rdata;

    mem_bus_if host_bus ();
    mem_bus_if engine_bus ();

    // host memory port drives the client side directly
    assign host_bus.req = mem_req;
    assign host_bus.we = mem_we;
    assign host_bus.addr = mem_addr;
    assign host_bus.wdata = mem_wdata;
    assign mem_gnt = host_bus.gnt;
    assign mem_rvalid = host_bus.rvalid;
    assign mem_rdata = host_bus.rdata;

    ctrl_regs u_ctrl_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .enable     (enable),
        .desc_valid (desc_valid),
        .desc_src   (desc_src),
        .desc_dst   (desc_dst),
        .desc_len   (desc_len),
        .desc_tag   (desc_tag),
        .desc_ready (desc_ready),
        .done       (done),
        .done_tag   (done_tag),
        .irq        (irq)
    );

    copy_engine u_copy_engine (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .desc_valid (desc_valid),
        .desc_src   (desc_src),
        .desc_dst   (desc_dst),
        .desc_len   (desc_len),
        .desc_tag   (desc_tag),
        .desc_ready (desc_ready),
        .done       (done),
        .done_tag   (done_tag),
        .bus        (engine_bus)
    );

    ram_arbiter u_ram_arbiter (
        .clk       (clk),
        .rst       (rst),
        .host      (host_bus),
        .engine    (engine_bus),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    local_ram u_local_ram (
        .clk       (clk),
        .rst       (rst),
        .ram_we    (ram_we),
        .ram_en    (ram_en),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* bench/dma_core_tb.sv */
// ========================================
// testbench for the DMA core, random host traffic and copies
// checked against a shadow RAM and register model
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "dma_core_params.svh"

module dma_core_tb;

    // generous bound over fill, sweeps, copies and polling
    localparam int TIMEOUT_CYCLES = 200000;
    localparam int GNT_LIMIT = 50;
    localparam int POLL_LIMIT = 2000;

    logic                    clk;
    logic                    rst;
    logic                    reg_wr;
    logic                    reg_rd;
    dma_core_pkg::reg_addr_t reg_addr;
    dma_core_pkg::data_t     reg_wdata;
    dma_core_pkg::data_t     reg_rdata;
    logic                    reg_rvalid;
    logic                    mem_req;
    logic                    mem_we;
    dma_core_pkg::ram_addr_t mem_addr;
    dma_core_pkg::data_t     mem_wdata;
    logic                    mem_gnt;
    logic                    mem_rvalid;
    dma_core_pkg::data_t     mem_rdata;
    logic                    irq;

    dma_core_pkg::data_t shadow [`RAM_DEPTH];
    dma_core_pkg::tag_t  last_tag;
    int                  done_count;
    int                  cycles;
    integer              seed;

    dma_core uut (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout, the run did not finish in time");
        end
    end

    task automatic check_data(input string name, input dma_core_pkg::data_t got,
                              input dma_core_pkg::data_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_on_error("data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
            stop_on_error("bit mismatch");
        end
    endtask

    function automatic dma_core_pkg::data_t status_word(input logic pend,
                                                        input dma_core_pkg::tag_t tag);
        dma_core_pkg::data_t w;
        w = '0;
        w[`DATA_W-1] = pend;
        w[`TAG_W-1:0] = tag;
        return w;
    endfunction

    function automatic dma_core_pkg::ram_addr_t wrap_addr(input int base, input int idx);
        return dma_core_pkg::ram_addr_t'((base + idx) % `RAM_DEPTH);
    endfunction

    function automatic logic is_mapped(input dma_core_pkg::reg_addr_t a);
        return a == `REG_ENABLE || a == `REG_SRC || a == `REG_DST || a == `REG_LEN ||
               a == `REG_TAG || a == `REG_STATUS || a == `REG_DONE_CNT;
    endfunction

    task automatic reg_write(input dma_core_pkg::reg_addr_t a, input dma_core_pkg::data_t d);
        @(posedge clk);
        reg_wr <= 1'b1;
        reg_addr <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // irq is sampled before the read can pop the status
    task automatic reg_read(input dma_core_pkg::reg_addr_t a, output dma_core_pkg::data_t d,
                            output logic irq_seen);
        @(posedge clk);
        reg_rd <= 1'b1;
        reg_addr <= a;
        @(negedge clk);
        irq_seen = irq;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        check_bit("reg_rvalid", reg_rvalid, 1'b1);
        d = reg_rdata;
    endtask

    task automatic mem_access(input logic we, input dma_core_pkg::ram_addr_t a,
                              input dma_core_pkg::data_t wd, output dma_core_pkg::data_t rd);
        int waited;
        @(posedge clk);
        mem_req <= 1'b1;
        mem_we <= we;
        mem_addr <= a;
        mem_wdata <= wd;
        waited = 0;
        @(negedge clk);
        while (!mem_gnt && waited < GNT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!mem_gnt) begin
            stop_on_error("host memory request was never granted");
        end else begin
            @(posedge clk);
            mem_req <= 1'b0;
            @(negedge clk);
            check_bit("mem_rvalid", mem_rvalid, !we);
            rd = mem_rdata;
        end
    endtask

    task automatic mem_write(input dma_core_pkg::ram_addr_t a, input dma_core_pkg::data_t d);
        dma_core_pkg::data_t unused;
        mem_access(1'b1, a, d, unused);
        shadow[a] = d;
    endtask

    task automatic mem_check(input dma_core_pkg::ram_addr_t a);
        dma_core_pkg::data_t got;
        mem_access(1'b0, a, '0, got);
        check_data("mem_rdata", got, shadow[a]);
    endtask

    task automatic sweep_ram();
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            mem_check(dma_core_pkg::ram_addr_t'(i));
        end
    endtask

    // model copies word by word in order, so overlap behaves as in the engine
    task automatic start_desc(input int src, input int dst, input int len,
                              input dma_core_pkg::tag_t tag);
        reg_write(`REG_SRC, src);
        reg_write(`REG_DST, dst);
        reg_write(`REG_LEN, len);
        reg_write(`REG_TAG, tag);
        for (int i = 0; i < len; i++) begin
            shadow[wrap_addr(dst, i)] = shadow[wrap_addr(src, i)];
        end
    endtask

    task automatic finish_desc(input int dst, input int len, input dma_core_pkg::tag_t tag);
        dma_core_pkg::data_t d;
        logic                irq_seen;
        int                  polls;
        polls = 0;
        d = '0;
        while (!d[`DATA_W-1] && polls < POLL_LIMIT) begin
            reg_read(`REG_STATUS, d, irq_seen);
            check_bit("irq", irq_seen, d[`DATA_W-1]);
            polls++;
        end
        if (!d[`DATA_W-1]) begin
            stop_on_error("descriptor never completed");
        end else begin
            last_tag = tag;
            done_count++;
            check_data("status", d, status_word(1'b1, tag));
            // second read sees the popped status
            reg_read(`REG_STATUS, d, irq_seen);
            check_data("status", d, status_word(1'b0, tag));
            check_bit("irq", irq, 1'b0);
            reg_read(`REG_DONE_CNT, d, irq_seen);
            check_data("done_cnt", d, done_count);
            for (int i = 0; i < len; i++) begin
                mem_check(wrap_addr(dst, i));
            end
        end
    endtask

    initial begin
        dma_core_pkg::data_t     d;
        dma_core_pkg::reg_addr_t a;
        dma_core_pkg::tag_t      tag;
        logic                    irq_seen;
        int                      len;
        seed = 70;
        cycles = 0;
        done_count = 0;
        last_tag = '0;
        rst <= 1'b1;
        reg_wr <= 1'b0;
        reg_rd <= 1'b0;
        reg_addr <= '0;
        reg_wdata <= '0;
        mem_req <= 1'b0;
        mem_we <= 1'b0;
        mem_addr <= '0;
        mem_wdata <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // host memory: fill, random overwrites, full readback
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            mem_write(dma_core_pkg::ram_addr_t'(i), $random(seed));
        end
        for (int i = 0; i < 200; i++) begin
            mem_write(dma_core_pkg::ram_addr_t'($random(seed)), $random(seed));
        end
        sweep_ram();

        // register readback and unmapped reads
        reg_write(`REG_ENABLE, 32'd1);
        reg_read(`REG_ENABLE, d, irq_seen);
        check_data("enable", d, 32'd1);
        reg_write(`REG_ENABLE, 32'd0);
        reg_read(`REG_ENABLE, d, irq_seen);
        check_data("enable", d, 32'd0);
        for (int i = 0; i < 4; i++) begin
            len = {$random(seed)} & 32'hFFFF;
            a = 12'(({$random(seed)} % `RAM_DEPTH));
            reg_write(`REG_SRC, a);
            reg_write(`REG_DST, len % `RAM_DEPTH);
            reg_write(`REG_LEN, len);
            reg_read(`REG_SRC, d, irq_seen);
            check_data("src", d, a);
            reg_read(`REG_DST, d, irq_seen);
            check_data("dst", d, len % `RAM_DEPTH);
            reg_read(`REG_LEN, d, irq_seen);
            check_data("len", d, len);
        end
        for (int i = 0; i < 12; i++) begin
            a = dma_core_pkg::reg_addr_t'($random(seed)) & 12'hFFC;
            if (!is_mapped(a)) begin
                reg_read(a, d, irq_seen);
                check_data("unmapped", d, 32'd0);
            end
        end

        // random descriptors, one of them zero length
        reg_write(`REG_ENABLE, 32'd1);
        for (int i = 0; i < 12; i++) begin
            len = (i == 3) ? 0 : {$random(seed)} % 40;
            tag = dma_core_pkg::tag_t'($random(seed));
            a = 12'({$random(seed)} % `RAM_DEPTH);
            d = {$random(seed)} % `RAM_DEPTH;
            start_desc(a, d, len, tag);
            finish_desc(d, len, tag);
        end
        sweep_ram();

        // disabled engine holds the descriptor
        reg_write(`REG_ENABLE, 32'd0);
        tag = dma_core_pkg::tag_t'($random(seed));
        start_desc(1000, 20, 30, tag);
        for (int i = 0; i < 200; i++) begin
            reg_read(`REG_STATUS, d, irq_seen);
            check_data("status", d, status_word(1'b0, last_tag));
            check_bit("irq", irq_seen, 1'b0);
        end
        reg_write(`REG_ENABLE, 32'd1);
        finish_desc(20, 30, tag);

        // host traffic in a disjoint region while a copy runs
        tag = dma_core_pkg::tag_t'($random(seed));
        start_desc(0, 128, 64, tag);
        for (int i = 0; i < 60; i++) begin
            a = 12'(512 + ({$random(seed)} % 256));
            if ($random(seed) & 1) begin
                mem_write(dma_core_pkg::ram_addr_t'(a), $random(seed));
            end else begin
                mem_check(dma_core_pkg::ram_addr_t'(a));
            end
        end
        finish_desc(128, 64, tag);
        sweep_ram();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dma_core.f */
+incdir+include
logic/dma_core_pkg.sv
logic/mem_bus_if.sv
logic/local_ram.sv
logic/ram_arbiter.sv
logic/copy_engine.sv
logic/ctrl_regs.sv
logic/dma_core.sv
bench/dma_core_tb.sv
